// File: bus_ctrl_fsm.sv
`default_nettype none

module bus_ctrl_fsm (
    input  wire                              sys_clk,
    input  wire                              rst_n_i,
    input  wire                              req_valid_i,
    input  wire                              req_we_i,
    input  wire  [periph_pkg::PERIPH_AW-1:0]  req_addr_i,
    input  wire  [periph_pkg::PERIPH_DW-1:0]  req_wdata_i,
    output logic                             req_ready_o,
    output logic                             resp_valid_o,
    output logic [periph_pkg::PERIPH_DW-1:0]  resp_rdata_o,
    output logic                             resp_err_o,
    input  wire                              resp_ready_i,
    input  wire                              por_done_i,
    input  wire  [periph_pkg::PERIPH_DW-1:0]  gpio_rdata_i,
    input  wire  [periph_pkg::PERIPH_DW-1:0]  reset_rdata_i,
    input  wire  [periph_pkg::PERIPH_DW-1:0]  timer_rdata_i,
    output logic                             gpio_stb_o,
    output logic                             reset_stb_o,
    output logic                             timer_stb_o,
    output logic                             bus_we_o,
    output logic [periph_pkg::REG_IDX_W-1:0]  bus_reg_idx_o,
    output logic [periph_pkg::PERIPH_DW-1:0]  bus_wdata_o
);
    import periph_pkg::*;

    // IDLE is neither flag set
    logic access_q;   // ACCESS, slave strobed
    logic respond_q;  // RESPOND, response held

    periph_addr_u         addr_q;
    logic                 we_q;
    logic [PERIPH_DW-1:0] wdata_q;
    logic [PERIPH_DW-1:0] rdata_q;
    logic                 err_q;

    slave_sel_e           sel;
    logic [PERIPH_DW-1:0] rd_mux;
    logic                 req_fire;

    assign req_ready_o = por_done_i & ~access_q & ~respond_q;
    assign req_fire    = req_valid_i & req_ready_o;

    always_ff @(posedge sys_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            access_q  <= 1'b0;
            respond_q <= 1'b0;
        end
        else
        begin
            access_q  <= req_fire;                        // Exactly one access cycle
            respond_q <= access_q | (respond_q & ~resp_ready_i);
        end
    end

    // Request capture
    always_ff @(posedge sys_clk)
    begin
        if (req_fire)
        begin
            addr_q.raw <= req_addr_i;
            we_q       <= req_we_i;
            wdata_q    <= req_wdata_i;
        end
    end

    // Address decoder, bits under the mask are ignored
    always_comb
    begin
        if ((addr_q.raw & ~GPIO_MASK) == (GPIO_BASE & ~GPIO_MASK))
            sel = SEL_GPIO;
        else if ((addr_q.raw & ~RESET_MASK) == (RESET_BASE & ~RESET_MASK))
            sel = SEL_RESET;
        else if ((addr_q.raw & ~TIMER_MASK) == (TIMER_BASE & ~TIMER_MASK))
            sel = SEL_TIMER;
        else
            sel = SEL_NONE;
    end

    assign gpio_stb_o  = access_q & (sel == SEL_GPIO);
    assign reset_stb_o = access_q & (sel == SEL_RESET);
    assign timer_stb_o = access_q & (sel == SEL_TIMER);

    assign bus_we_o      = we_q;
    assign bus_reg_idx_o = addr_q.fields.reg_idx;
    assign bus_wdata_o   = wdata_q;

    // Read data select; writes and unmapped accesses answer zero
    always_comb
    begin
        rd_mux = '0;
        if (!we_q)
        begin
            case (sel)
                SEL_GPIO:  rd_mux = gpio_rdata_i;
                SEL_RESET: rd_mux = reset_rdata_i;
                SEL_TIMER: rd_mux = timer_rdata_i;
                default:   rd_mux = '0;
            endcase
        end
    end

    // Response held stable through RESPOND
    always_ff @(posedge sys_clk)
    begin
        if (access_q)
        begin
            rdata_q <= rd_mux;
            err_q   <= (sel == SEL_NONE);
        end
    end

    assign resp_valid_o = respond_q;
    assign resp_rdata_o = rdata_q;
    assign resp_err_o   = err_q;

endmodule

`default_nettype wire

// File: gpio_regs.sv
`default_nettype none

module gpio_regs (
    input  wire                              sys_clk,
    input  wire                              rst_n_i,
    input  wire                              clr_i,
    input  wire                              stb_i,
    input  wire                              we_i,
    input  wire  [periph_pkg::REG_IDX_W-1:0]  reg_idx_i,
    input  wire  [periph_pkg::PERIPH_DW-1:0]  wdata_i,
    input  wire  [periph_pkg::GPIO_W-1:0]     gpio_i,
    output logic [periph_pkg::PERIPH_DW-1:0]  rdata_o,
    output logic [periph_pkg::GPIO_W-1:0]     gpio_o,
    output logic [periph_pkg::GPIO_W-1:0]     gpio_oe_o
);
    import periph_pkg::*;

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] dir_q;     // 1 drives the pin
    logic [GPIO_W-1:0] in_meta_q;
    logic [GPIO_W-1:0] in_sync_q;

    always_ff @(posedge sys_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            out_q <= '0;
            dir_q <= '0;
        end
        else if (clr_i)
        begin
            out_q <= '0;
            dir_q <= '0;
        end
        else if (stb_i && we_i)
        begin
            if (reg_idx_i == GPIO_OUT_IDX)
                out_q <= wdata_i[GPIO_W-1:0];
            if (reg_idx_i == GPIO_DIR_IDX)
                dir_q <= wdata_i[GPIO_W-1:0];
        end
    end

    // Two-stage synchroniser on the pins
    always_ff @(posedge sys_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end
        else
        begin
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_comb
    begin
        rdata_o = '0;
        case (reg_idx_i)
            GPIO_OUT_IDX: rdata_o[GPIO_W-1:0] = out_q;
            GPIO_DIR_IDX: rdata_o[GPIO_W-1:0] = dir_q;
            GPIO_IN_IDX:  rdata_o[GPIO_W-1:0] = in_sync_q;
            default:      rdata_o = '0;         // Unused slot
        endcase
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

endmodule

`default_nettype wire

// File: periph_pkg.sv
`default_nettype none

package periph_pkg;

    localparam int PERIPH_AW = 12;  // Byte address
    localparam int PERIPH_DW = 32;
    localparam int GPIO_W    = 8;
    localparam int REG_IDX_W = 2;

    // One bus address word, seen flat by the decoder and split by the slaves
    typedef union packed {
        logic [PERIPH_AW-1:0] raw;
        struct packed {
            logic [7:0]           page;
            logic [REG_IDX_W-1:0] reg_idx;
            logic [1:0]           byte_off;
        } fields;
    } periph_addr_u;

    typedef enum logic [1:0] {
        SEL_GPIO,
        SEL_RESET,
        SEL_TIMER,
        SEL_NONE
    } slave_sel_e;

    // Address map, mask bits are don't-care
    localparam logic [PERIPH_AW-1:0] GPIO_BASE  = 12'h000;
    localparam logic [PERIPH_AW-1:0] GPIO_MASK  = 12'h00F;
    localparam logic [PERIPH_AW-1:0] RESET_BASE = 12'h030;
    localparam logic [PERIPH_AW-1:0] RESET_MASK = 12'h007;
    localparam logic [PERIPH_AW-1:0] TIMER_BASE = 12'h100;
    localparam logic [PERIPH_AW-1:0] TIMER_MASK = 12'h00F;

    // GPIO registers
    localparam logic [REG_IDX_W-1:0] GPIO_OUT_IDX = 2'd0;
    localparam logic [REG_IDX_W-1:0] GPIO_DIR_IDX = 2'd1;
    localparam logic [REG_IDX_W-1:0] GPIO_IN_IDX  = 2'd2;

    // Timer registers
    localparam logic [REG_IDX_W-1:0] TMR_COUNT_IDX   = 2'd0;
    localparam logic [REG_IDX_W-1:0] TMR_COMPARE_IDX = 2'd1;
    localparam logic [REG_IDX_W-1:0] TMR_STATUS_IDX  = 2'd2;
    localparam logic [REG_IDX_W-1:0] TMR_CTRL_IDX    = 2'd3;

    localparam logic [4:0] POR_CYCLES = 5'd16;  // Power-on reset length in clocks

endpackage

`default_nettype wire

// File: periph_soc_top.sv
`default_nettype none

module periph_soc_top (
    input  wire                             sys_clk,
    input  wire                             rst_n_i,
    // Request channel
    input  wire                             req_valid_i,
    input  wire                             req_we_i,
    input  wire  [periph_pkg::PERIPH_AW-1:0] req_addr_i,
    input  wire  [periph_pkg::PERIPH_DW-1:0] req_wdata_i,
    output logic                            req_ready_o,
    // Response channel
    output logic                            resp_valid_o,
    output logic [periph_pkg::PERIPH_DW-1:0] resp_rdata_o,
    output logic                            resp_err_o,
    input  wire                             resp_ready_i,
    // GPIO pins and timer interrupt
    input  wire  [periph_pkg::GPIO_W-1:0]    gpio_i,
    output logic [periph_pkg::GPIO_W-1:0]    gpio_o,
    output logic [periph_pkg::GPIO_W-1:0]    gpio_oe_o,
    output logic                            timer_irq_o
);
    import periph_pkg::*;

    logic                 gpio_stb, reset_stb, timer_stb;
    logic                 bus_we;
    logic [REG_IDX_W-1:0] bus_reg_idx;
    logic [PERIPH_DW-1:0] bus_wdata;
    logic [PERIPH_DW-1:0] gpio_rdata, reset_rdata, timer_rdata;
    logic                 por_done;
    logic                 periph_clr;  // Software peripheral reset

    bus_ctrl_fsm bus_ctrl_inst (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .resp_err_o   (resp_err_o),
        .resp_ready_i (resp_ready_i),
        .por_done_i   (por_done),
        .gpio_rdata_i (gpio_rdata),
        .reset_rdata_i(reset_rdata),
        .timer_rdata_i(timer_rdata),
        .gpio_stb_o   (gpio_stb),
        .reset_stb_o  (reset_stb),
        .timer_stb_o  (timer_stb),
        .bus_we_o     (bus_we),
        .bus_reg_idx_o(bus_reg_idx),
        .bus_wdata_o  (bus_wdata)
    );

    por_reset_ctrl reset_ctrl_inst (
        .sys_clk     (sys_clk),
        .rst_n_i     (rst_n_i),
        .stb_i       (reset_stb),
        .we_i        (bus_we),
        .wdata_i     (bus_wdata),
        .rdata_o     (reset_rdata),
        .por_done_o  (por_done),
        .periph_clr_o(periph_clr)
    );

    gpio_regs gpio_inst (
        .sys_clk  (sys_clk),
        .rst_n_i  (rst_n_i),
        .clr_i    (periph_clr),
        .stb_i    (gpio_stb),
        .we_i     (bus_we),
        .reg_idx_i(bus_reg_idx),
        .wdata_i  (bus_wdata),
        .gpio_i   (gpio_i),
        .rdata_o  (gpio_rdata),
        .gpio_o   (gpio_o),
        .gpio_oe_o(gpio_oe_o)
    );

    tick_timer timer_inst (
        .sys_clk  (sys_clk),
        .rst_n_i  (rst_n_i),
        .clr_i    (periph_clr),
        .stb_i    (timer_stb),
        .we_i     (bus_we),
        .reg_idx_i(bus_reg_idx),
        .wdata_i  (bus_wdata),
        .rdata_o  (timer_rdata),
        .irq_o    (timer_irq_o)
    );

endmodule

`default_nettype wire

// File: por_reset_ctrl.sv
`default_nettype none

module por_reset_ctrl (
    input  wire                             sys_clk,
    input  wire                             rst_n_i,
    input  wire                             stb_i,
    input  wire                             we_i,
    input  wire  [periph_pkg::PERIPH_DW-1:0] wdata_i,
    output logic [periph_pkg::PERIPH_DW-1:0] rdata_o,
    output logic                            por_done_o,
    output logic                            periph_clr_o
);
    import periph_pkg::*;

    logic [$bits(POR_CYCLES)-1:0] por_cnt_q;
    logic                         por_done;

    // Saturates at POR_CYCLES
    always_ff @(posedge sys_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            por_cnt_q <= '0;
        else if (!por_done)
            por_cnt_q <= por_cnt_q + 1'b1;
    end

    assign por_done   = (por_cnt_q == POR_CYCLES);
    assign por_done_o = por_done;

    // Status register, bit 0 is POR complete
    always_comb
    begin
        rdata_o    = '0;
        rdata_o[0] = por_done;
    end

    // Software reset of the peripherals, lasts the access cycle only
    assign periph_clr_o = stb_i & we_i & wdata_i[0];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then decide on the log contents
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_periph_soc -Mdir obj_dir -o sim_periph || exit 1

./obj_dir/sim_periph > sim.log 2>&1 || echo "Something failed" >> sim.log
cat sim.log

grep -q "Something failed" sim.log && exit 1 || exit 0

// File: tb_periph_soc.sv
`default_nettype none

module tb_periph_soc;
    timeunit 1ns;
    timeprecision 1ps;
    import periph_pkg::*;

    localparam int N_ACCESSES = 42;  // Bus accesses over all tests
    localparam int ACC_CYCLES = 40;  // Allowance per access under back-pressure
    localparam int MAX_CYCLES = 5 + int'(POR_CYCLES) + N_ACCESSES * ACC_CYCLES + 60 + 400;

    logic        sys_clk;
    logic        rst_n_i;
    logic        req_valid_i;
    logic        req_we_i;
    logic [11:0] req_addr_i;
    logic [31:0] req_wdata_i;
    logic        req_ready_o;
    logic        resp_valid_o;
    logic [31:0] resp_rdata_o;
    logic        resp_err_o;
    logic        resp_ready_i;
    logic [7:0]  gpio_i;
    logic [7:0]  gpio_o;
    logic [7:0]  gpio_oe_o;
    logic        timer_irq_o;

    logic [16:0] lfsr_q;
    logic        bp_en;        // Random resp_ready_i stalls
    int          error_cnt;
    int          tests_run;
    int          tests_failed;
    int          req_cnt;
    int          resp_cnt;
    int          cycle_cnt;

    // Expected responses in request order
    logic [31:0] exp_data_q[$];
    logic        exp_err_q[$];
    logic        exp_min_q[$];
    logic [31:0] exp_d;
    logic        exp_e;
    logic        exp_m;

    // Reference register state
    logic [7:0]  ref_out;
    logic [7:0]  ref_dir;
    logic [7:0]  ref_gpio_in;
    logic [31:0] ref_count;
    logic [31:0] ref_compare;
    logic        ref_en;
    logic        ref_match;

    periph_soc_top dut (
        .sys_clk     (sys_clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .resp_valid_o(resp_valid_o),
        .resp_rdata_o(resp_rdata_o),
        .resp_err_o  (resp_err_o),
        .resp_ready_i(resp_ready_i),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .gpio_oe_o   (gpio_oe_o),
        .timer_irq_o (timer_irq_o)
    );

    always #20 sys_clk = ~sys_clk;

    // x^17 + x^14 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[16] ^ lfsr_q[13];
        lfsr_q = {lfsr_q[15:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic hits(input logic [11:0] addr, input logic [11:0] base,
                                  input logic [11:0] mask);
        return ((addr ^ base) & ~mask) == 12'h000;
    endfunction

    function automatic logic [11:0] reg_addr(input logic [11:0] base, input logic [1:0] idx);
        return base | {8'h00, idx, 2'b00};
    endfunction

    // Works out the expected response of one access and steps the model
    function automatic void ref_access(input logic we, input logic [11:0] addr,
                                       input logic [31:0] wdata, output logic [31:0] data,
                                       output logic err, output logic at_least);
        logic [1:0] idx;
        idx      = addr[3:2];
        data     = '0;
        err      = 1'b0;
        at_least = 1'b0;
        if (hits(addr, GPIO_BASE, GPIO_MASK))
        begin
            if (we && idx == 2'd0)
                ref_out = wdata[7:0];
            else if (we && idx == 2'd1)
                ref_dir = wdata[7:0];
            else if (!we && idx == 2'd0)
                data = {24'h0, ref_out};
            else if (!we && idx == 2'd1)
                data = {24'h0, ref_dir};
            else if (!we && idx == 2'd2)
                data = {24'h0, ref_gpio_in};
        end
        else if (hits(addr, RESET_BASE, RESET_MASK))
        begin
            if (we && wdata[0])
            begin
                ref_out     = '0;
                ref_dir     = '0;
                ref_count   = '0;
                ref_compare = '0;
                ref_en      = 1'b0;
                ref_match   = 1'b0;
            end
            else if (!we)
                data = 32'h1;  // POR done
        end
        else if (hits(addr, TIMER_BASE, TIMER_MASK))
        begin
            if (we)
            begin
                case (idx)
                    2'd0: ref_count = wdata;
                    2'd1: ref_compare = wdata;
                    2'd2: ref_match = ref_match & ~wdata[0];
                    default: ref_en = wdata[0];
                endcase
            end
            else
            begin
                case (idx)
                    2'd0:
                    begin
                        at_least = ref_en;  // Running count only has a lower bound
                        data     = (ref_en && ref_match) ? ref_compare : ref_count;
                    end
                    2'd1: data = ref_compare;
                    2'd2: data = {31'h0, ref_match};
                    default: data = {31'h0, ref_en};
                endcase
            end
        end
        else
            err = 1'b1;
    endfunction

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        error_cnt++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            report(name, got, exp);
    endtask

    // Single access that returns once its response is consumed
    task automatic bus_access(input logic we, input logic [11:0] addr, input logic [31:0] wdata);
        logic [31:0] d;
        logic        e;
        logic        m;
        @(negedge sys_clk);
        req_valid_i = 1'b1;
        req_we_i    = we;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        while (!req_ready_o)
            @(negedge sys_clk);
        @(posedge sys_clk);  // Handshake edge
        ref_access(we, addr, wdata, d, e, m);
        exp_data_q.push_back(d);
        exp_err_q.push_back(e);
        exp_min_q.push_back(m);
        req_cnt++;
        @(negedge sys_clk);
        req_valid_i = 1'b0;
        while (resp_cnt != req_cnt)
            @(posedge sys_clk);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_cnt != errs_before)
        begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_cnt - errs_before);
        end
        else
            $display("Test %s: done, no errors", name);
    endtask

    // Response compare
    always @(posedge sys_clk)
    begin
        if (rst_n_i && resp_valid_o && resp_ready_i)
        begin
            if (exp_data_q.size() == 0)
            begin
                $display("Error at %0t ns: a response came with no request open", $time);
                error_cnt++;
            end
            else
            begin
                exp_d = exp_data_q.pop_front();
                exp_e = exp_err_q.pop_front();
                exp_m = exp_min_q.pop_front();
                if (resp_err_o !== exp_e)
                    report("resp_err_o", {31'h0, resp_err_o}, {31'h0, exp_e});
                if (exp_m)
                begin
                    if (resp_rdata_o < exp_d)
                    begin
                        $display("MISMATCH at %0t ns: resp_rdata_o got 0x%08h expected >= 0x%08h",
                                 $time, resp_rdata_o, exp_d);
                        error_cnt++;
                    end
                end
                else if (resp_rdata_o !== exp_d)
                    report("resp_rdata_o", resp_rdata_o, exp_d);
            end
            resp_cnt++;
        end
    end

    always @(negedge sys_clk)
    begin
        if (bp_en)
            resp_ready_i = lfsr_bit() & lfsr_bit();  // High one cycle in four
        else
            resp_ready_i = 1'b1;
    end

    always @(posedge sys_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES)
        begin
            $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] n;
        logic [31:0] v;
        logic [31:0] w;
        logic [11:0] a;
        int          errs;
        int          r;
        sys_clk      = 1'b0;
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_we_i     = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        resp_ready_i = 1'b1;
        gpio_i       = '0;
        lfsr_q       = 17'd75825;
        bp_en        = 1'b0;
        error_cnt    = 0;
        tests_run    = 0;
        tests_failed = 0;
        req_cnt      = 0;
        resp_cnt     = 0;
        cycle_cnt    = 0;
        ref_out      = '0;
        ref_dir      = '0;
        ref_gpio_in  = '0;
        ref_count    = '0;
        ref_compare  = '0;
        ref_en       = 1'b0;
        ref_match    = 1'b0;
        repeat (5) @(negedge sys_clk);
        rst_n_i = 1'b1;

        // Power-on reset
        errs = error_cnt;
        n    = 0;
        while (!req_ready_o)
        begin
            @(negedge sys_clk);
            n++;
        end
        check_value("req_ready_o rise cycle", n, {27'h0, POR_CYCLES});
        bus_access(1'b0, RESET_BASE, '0);
        finish_test("power-on reset", errs);

        errs = error_cnt;
        for (r = 0; r < 4; r++)
        begin
            v = rand_bits(32);
            w = rand_bits(32);
            bus_access(1'b1, reg_addr(GPIO_BASE, GPIO_OUT_IDX), v);
            bus_access(1'b1, reg_addr(GPIO_BASE, GPIO_DIR_IDX), w);
            @(negedge sys_clk);
            check_value("gpio_o", {24'h0, gpio_o}, {24'h0, v[7:0]});
            check_value("gpio_oe_o", {24'h0, gpio_oe_o}, {24'h0, w[7:0]});
            bus_access(1'b0, reg_addr(GPIO_BASE, GPIO_OUT_IDX), '0);
            bus_access(1'b0, reg_addr(GPIO_BASE, GPIO_DIR_IDX), '0);
        end
        finish_test("GPIO registers", errs);

        errs = error_cnt;
        for (r = 0; r < 3; r++)
        begin
            @(negedge sys_clk);
            v           = rand_bits(8);
            gpio_i      = v[7:0];
            ref_gpio_in = v[7:0];
            repeat (4) @(negedge sys_clk);  // Past the synchroniser
            bus_access(1'b0, reg_addr(GPIO_BASE, GPIO_IN_IDX), '0);
        end
        finish_test("GPIO input", errs);

        errs = error_cnt;
        v = 32'd8 + rand_bits(3);
        bus_access(1'b1, reg_addr(TIMER_BASE, TMR_COMPARE_IDX), v);
        bus_access(1'b1, reg_addr(TIMER_BASE, TMR_COUNT_IDX), '0);
        bus_access(1'b1, reg_addr(TIMER_BASE, TMR_CTRL_IDX), 32'h1);
        n = 0;
        while (!timer_irq_o && n <= v + 4)
        begin
            @(negedge sys_clk);
            n++;
        end
        if (!timer_irq_o)
        begin
            $display("Error at %0t ns: timer_irq_o did not rise within %0d cycles", $time, v + 4);
            error_cnt++;
        end
        ref_match = 1'b1;  // Count has run past the compare value
        bus_access(1'b0, reg_addr(TIMER_BASE, TMR_COUNT_IDX), '0);
        bus_access(1'b0, reg_addr(TIMER_BASE, TMR_STATUS_IDX), '0);
        bus_access(1'b1, reg_addr(TIMER_BASE, TMR_STATUS_IDX), 32'h1);
        bus_access(1'b0, reg_addr(TIMER_BASE, TMR_STATUS_IDX), '0);
        @(negedge sys_clk);
        if (timer_irq_o !== 1'b0)
        begin
            $display("Error at %0t ns: timer_irq_o stayed high after the STATUS clear", $time);
            error_cnt++;
        end
        finish_test("timer", errs);

        // Unmapped accesses under back-pressure
        errs  = error_cnt;
        bp_en = 1'b1;
        for (r = 0; r < 8; r++)
        begin
            w = rand_bits(12);
            a = w[11:0];
            while (hits(a, GPIO_BASE, GPIO_MASK) || hits(a, RESET_BASE, RESET_MASK)
                   || hits(a, TIMER_BASE, TIMER_MASK))
            begin
                w = rand_bits(12);
                a = w[11:0];
            end
            bus_access(lfsr_bit(), a, rand_bits(32));
        end
        bp_en = 1'b0;
        finish_test("unmapped and back-pressure", errs);

        errs = error_cnt;
        bus_access(1'b1, reg_addr(GPIO_BASE, GPIO_OUT_IDX), 32'hA5);
        bus_access(1'b1, reg_addr(GPIO_BASE, GPIO_DIR_IDX), 32'h3C);
        bus_access(1'b1, reg_addr(TIMER_BASE, TMR_CTRL_IDX), 32'h1);
        bus_access(1'b1, RESET_BASE, 32'h1);
        @(negedge sys_clk);
        check_value("gpio_o", {24'h0, gpio_o}, 32'h0);
        check_value("gpio_oe_o", {24'h0, gpio_oe_o}, 32'h0);
        bus_access(1'b0, reg_addr(GPIO_BASE, GPIO_OUT_IDX), '0);
        bus_access(1'b0, reg_addr(GPIO_BASE, GPIO_DIR_IDX), '0);
        bus_access(1'b0, reg_addr(TIMER_BASE, TMR_CTRL_IDX), '0);
        finish_test("software reset", errs);

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_cnt);
        if (error_cnt == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_periph_soc_assert.sv
`default_nettype none

module tb_periph_soc_assert (
    input wire        sys_clk,
    input wire        rst_n_i,
    input wire        req_ready_o,
    input wire        resp_valid_o,
    input wire [31:0] resp_rdata_o,
    input wire        resp_err_o,
    input wire        resp_ready_i,
    input wire        por_done_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // A stalled response holds still
    resp_stable_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        resp_valid_o && !resp_ready_i |=>
            resp_valid_o && $stable(resp_rdata_o) && $stable(resp_err_o))
        else $error("resp_valid_o or its data changed under back-pressure");

    one_open_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !(req_ready_o && resp_valid_o))
        else $error("req_ready_o high while a response is pending");

    por_gate_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !por_done_i |-> !req_ready_o)
        else $error("req_ready_o high before power-on reset finished");

endmodule

bind bus_ctrl_fsm tb_periph_soc_assert assert_inst (
    .sys_clk     (sys_clk),
    .rst_n_i     (rst_n_i),
    .req_ready_o (req_ready_o),
    .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o),
    .resp_err_o  (resp_err_o),
    .resp_ready_i(resp_ready_i),
    .por_done_i  (por_done_i)
);

`default_nettype wire

// File: tick_timer.sv
`default_nettype none

module tick_timer (
    input  wire                              sys_clk,
    input  wire                              rst_n_i,
    input  wire                              clr_i,
    input  wire                              stb_i,
    input  wire                              we_i,
    input  wire  [periph_pkg::REG_IDX_W-1:0]  reg_idx_i,
    input  wire  [periph_pkg::PERIPH_DW-1:0]  wdata_i,
    output logic [periph_pkg::PERIPH_DW-1:0]  rdata_o,
    output logic                             irq_o
);
    import periph_pkg::*;

    logic [PERIPH_DW-1:0] count_q;
    logic [PERIPH_DW-1:0] compare_q;
    logic                 en_q;     // CTRL bit 0
    logic                 match_q;  // Sticky, STATUS bit 0
    logic                 wr;
    logic                 hit;

    assign wr  = stb_i & we_i;
    assign hit = en_q & (count_q == compare_q);

    always_ff @(posedge sys_clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            count_q   <= '0;
            compare_q <= '0;
            en_q      <= 1'b0;
            match_q   <= 1'b0;
        end
        else if (clr_i)
        begin
            count_q   <= '0;
            compare_q <= '0;
            en_q      <= 1'b0;
            match_q   <= 1'b0;
        end
        else
        begin
            if (wr && reg_idx_i == TMR_COUNT_IDX)
                count_q <= wdata_i;            // Load wins over counting
            else if (en_q)
                count_q <= count_q + 1'b1;

            if (wr && reg_idx_i == TMR_COMPARE_IDX)
                compare_q <= wdata_i;

            if (wr && reg_idx_i == TMR_CTRL_IDX)
                en_q <= wdata_i[0];

            // A fresh match is not lost to a clear in the same cycle
            if (hit)
                match_q <= 1'b1;
            else if (wr && reg_idx_i == TMR_STATUS_IDX && wdata_i[0])
                match_q <= 1'b0;
        end
    end

    always_comb
    begin
        rdata_o = '0;
        case (reg_idx_i)
            TMR_COUNT_IDX:   rdata_o = count_q;
            TMR_COMPARE_IDX: rdata_o = compare_q;
            TMR_STATUS_IDX:  rdata_o[0] = match_q;
            TMR_CTRL_IDX:    rdata_o[0] = en_q;
            default:         rdata_o = '0;
        endcase
    end

    assign irq_o = match_q;

endmodule

`default_nettype wire

// File: vlog.f
periph_pkg.sv
por_reset_ctrl.sv
gpio_regs.sv
tick_timer.sv
bus_ctrl_fsm.sv
periph_soc_top.sv
tb_periph_soc_assert.sv
tb_periph_soc.sv
